// ==== run_sim.sh ====
#!/bin/sh
# build and run the scheduler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_sched_unit -o tb_sched_unit
./obj_dir/tb_sched_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// ==== sim.f ====
+incdir+sim
verilog/sched_pkg.sv
verilog/sched_ptr_ring.sv
verilog/sched_entry.sv
verilog/sched_age_picker.sv
verilog/sched_issue_queue.sv
verilog/sched_exec_pipe.sv
verilog/sched_unit.sv
sim/tb_sched_unit.sv

// ==== sim/tb_sched_checks.svh ====
`ifndef TB_SCHED_CHECKS_SVH
`define TB_SCHED_CHECKS_SVH

logic [15:0] lfsr_state;
int          n_err_done;
int          n_err_credit;
int          n_err_other;

// 16-bit galois lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// one lfsr step per bit taken
function automatic int take_bits(input int n);
  int v;
  v = 0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_step(lfsr_state);
    v = (v << 1) | int'(lfsr_state[0]);
  end
  return v;
endfunction

// id and exc only matter when valid
task automatic check_done(input done_rpt_t act, input done_rpt_t exp, input string what);
  if (act.valid !== exp.valid ||
      (exp.valid && (act.cmt_id !== exp.cmt_id || act.exc_valid !== exp.exc_valid))) begin
    n_err_done++;
    $display("[FAIL] %0t: %s: got valid=%0b id=%0d exc=%0b, expected valid=%0b id=%0d exc=%0b",
             $time, what, act.valid, act.cmt_id, act.exc_valid,
             exp.valid, exp.cmt_id, exp.exc_valid);
  end
endtask

task automatic check_credit(input int act, input int exp, input string what);
  if (act != exp) begin
    n_err_credit++;
    $display("[FAIL] %0t: %s: got %0d, expected %0d", $time, what, act, exp);
  end
endtask

task automatic flag_error(input string msg);
  n_err_other++;
  $display("error at %0t: %s", $time, msg);
endtask

`endif

// ==== sim/tb_sched_unit.sv ====
`default_nettype none

module tb_sched_unit;

  import sched_pkg::*;

  localparam int ENTRY_SIZE = 8;
  localparam int EXEC_LAT   = 2;
  localparam int PERIOD     = 8;
  localparam int RST_CYC    = 16;
  localparam int IDLE_CYC   = 8;
  localparam int ORD_CYC    = 60; // leaves both pointers mid-ring for the fill
  localparam int RAND_CYC   = 2000;
  localparam int DRAIN_CYC  = ENTRY_SIZE * (EXEC_LAT + 4);
  localparam int STIM_CYC   = RST_CYC + IDLE_CYC + ORD_CYC + ENTRY_SIZE + 4 + RAND_CYC;
  localparam int WDOG_TIME  = (STIM_CYC + 3 * DRAIN_CYC) * PERIOD;
  localparam int NUM_ID     = 1 << CMT_W;
  localparam int EXT_BASE   = 16; // external tags 16..23 and internal rd tags 0..15
  localparam int EXT_NUM    = 8;
  localparam int MODE_RAND  = 0;
  localparam int MODE_READY = 1;
  localparam int MODE_FILL  = 2;

  logic      clk;
  logic      arst_n;
  logic      disp_valid;
  disp_t     disp;
  wakeup_t   ext_wakeup;
  done_rpt_t done_report;
  logic      credit_ret;

  `include "tb_sched_checks.svh"

  // reference model
  int               credits;
  int               total_disp;
  int               total_ret;
  int               n_pending;
  int               cyc;
  int               next_id;
  int               ord_next;
  bit               ordered;
  bit               pend     [NUM_ID];
  op_e              op_of    [NUM_ID];
  logic [TAG_W-1:0] rd_of    [NUM_ID];
  int               rpt_cyc  [NUM_ID];
  int               src_prod [NUM_ID][2]; // producer commit id or -1
  int               src_ext  [NUM_ID][2]; // waited external tag or -1
  int               src_wake [NUM_ID][2];
  int               tag_prod [32];        // outstanding producer of each tag

  sched_unit #(.ENTRY_SIZE(ENTRY_SIZE), .EXEC_LAT(EXEC_LAT)) uut (
    .i_clk         (clk),
    .i_arst_n      (arst_n),
    .i_disp_valid  (disp_valid),
    .i_disp        (disp),
    .i_ext_wakeup  (ext_wakeup),
    .o_done_report (done_report),
    .o_credit_ret  (credit_ret)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  task automatic check_deps(input int id);
    int p;
    for (int s = 0; s < 2; s++) begin
      p = src_prod[id][s];
      if (p >= 0 && (rpt_cyc[p] < 0 || rpt_cyc[p] >= cyc)) begin
        flag_error($sformatf("commit id %0d reported before its producer %0d", id, p));
      end
      if (src_ext[id][s] >= 0 && src_wake[id][s] < 0) begin
        flag_error($sformatf("commit id %0d reported before tag %0d was driven",
                             id, src_ext[id][s]));
      end else if (src_ext[id][s] >= 0 && cyc - src_wake[id][s] < EXEC_LAT + 1) begin
        flag_error($sformatf("commit id %0d reported too soon after tag %0d",
                             id, src_ext[id][s]));
      end
    end
  endtask

  // outputs settle one unit after the edge and inputs go idle
  task automatic step_cycle();
    done_rpt_t exp;
    int        id;
    @(posedge clk);
    #1;
    cyc++;
    disp_valid = 1'b0;
    ext_wakeup = '0;
    if (done_report.valid) begin
      id = int'(done_report.cmt_id);
      if (ordered) begin
        exp = '{valid: 1'b1, cmt_id: CMT_W'(ord_next), exc_valid: op_of[ord_next] == OP_TRAP};
        check_done(done_report, exp, "age order");
        ord_next = (ord_next + 1) % NUM_ID;
      end
      if (!pend[id]) begin
        flag_error($sformatf("commit id %0d reported but not outstanding", id));
      end else begin
        exp = '{valid: 1'b1, cmt_id: CMT_W'(id), exc_valid: op_of[id] == OP_TRAP};
        check_done(done_report, exp, "done report");
        check_deps(id);
        pend[id] = 1'b0;
        rpt_cyc[id] = cyc;
        n_pending--;
        if (tag_prod[rd_of[id]] == id) tag_prod[rd_of[id]] = -1; // tag free again
      end
    end
    if (credit_ret) begin
      total_ret++;
      credits++;
      if (credits > ENTRY_SIZE) check_credit(credits, ENTRY_SIZE, "credit count over ring size");
    end
  endtask

  task automatic dispatch_op(input int mode);
    int               id;
    int               rd;
    logic [TAG_W-1:0] tag [2];
    logic             rdy [2];
    logic             vld [2];
    op_e              op;
    id = next_id;
    for (int s = 0; s < 2; s++) begin
      src_prod[id][s] = -1;
      src_ext[id][s]  = -1;
      src_wake[id][s] = -1;
      vld[s] = (take_bits(1) != 0);
      if (mode == MODE_FILL) begin
        vld[s] = (s == 0); // held until the drain drives the tag
        tag[s] = TAG_W'(EXT_BASE);
        rdy[s] = 1'b0;
        if (vld[s]) src_ext[id][s] = EXT_BASE;
      end else if (mode == MODE_READY) begin
        tag[s] = TAG_W'(take_bits(TAG_W));
        rdy[s] = 1'b1;
      end else if (take_bits(2) == 0) begin
        tag[s] = TAG_W'(EXT_BASE + take_bits(3));
        rdy[s] = (take_bits(1) != 0);
        if (vld[s] && !rdy[s]) src_ext[id][s] = int'(tag[s]);
      end else begin
        tag[s] = TAG_W'(take_bits(4));
        rdy[s] = (tag_prod[tag[s]] < 0);
        if (vld[s] && !rdy[s]) src_prod[id][s] = tag_prod[tag[s]];
      end
    end
    rd = take_bits(4);
    while (tag_prod[rd] >= 0) rd = (rd + 1) % EXT_BASE;
    op = op_e'(2'(take_bits(2)));
    disp = '{cmt_id: CMT_W'(id), op: op, rd: TAG_W'(rd),
             rs1_valid: vld[0], rs1_tag: tag[0], rs1_ready: rdy[0],
             rs2_valid: vld[1], rs2_tag: tag[1], rs2_ready: rdy[1]};
    disp_valid = 1'b1;
    tag_prod[rd] = id;
    pend[id]     = 1'b1;
    op_of[id]    = op;
    rd_of[id]    = TAG_W'(rd);
    rpt_cyc[id]  = -1;
    n_pending++;
    credits--;
    total_disp++;
    next_id = (next_id + 1) % NUM_ID;
  endtask

  // after any dispatch of the same cycle
  task automatic drive_ext(input int tag);
    ext_wakeup = '{valid: 1'b1, tag: TAG_W'(tag)};
    for (int id = 0; id < NUM_ID; id++) begin
      for (int s = 0; s < 2; s++) begin
        if (pend[id] && src_ext[id][s] == tag && src_wake[id][s] < 0) src_wake[id][s] = cyc;
      end
    end
  endtask

  task automatic drain_ring();
    int k;
    k = 0;
    while ((n_pending != 0 || credits != ENTRY_SIZE) && k < DRAIN_CYC) begin
      step_cycle();
      drive_ext(EXT_BASE + (k % EXT_NUM)); // sweep every external tag
      k++;
    end
    check_credit(credits, ENTRY_SIZE, "credits after drain");
    if (n_pending != 0) flag_error($sformatf("%0d ops were never reported", n_pending));
  endtask

  initial begin
    arst_n = 1'b0;
    disp_valid = 1'b0;
    disp = '0;
    ext_wakeup = '0;
    lfsr_state = 16'd4238;
    credits = ENTRY_SIZE;
    total_disp = 0;
    total_ret = 0;
    n_pending = 0;
    cyc = 0;
    next_id = 0;
    ord_next = 0;
    ordered = 1'b0;
    n_err_done = 0;
    n_err_credit = 0;
    n_err_other = 0;
    for (int t = 0; t < 32; t++) tag_prod[t] = -1;
    for (int id = 0; id < NUM_ID; id++) begin
      pend[id] = 1'b0;
      rpt_cyc[id] = -1;
    end
    repeat (RST_CYC) @(posedge clk);
    #1 arst_n = 1'b1;
    repeat (IDLE_CYC) begin
      step_cycle();
      check_done(done_report, '0, "done report before dispatch");
      check_credit(int'(credit_ret), 0, "credit pulse before dispatch");
    end
    // independent ready ops over several ring wraps
    ordered = 1'b1;
    ord_next = next_id;
    repeat (ORD_CYC) begin
      step_cycle();
      if (credits > 0) dispatch_op(MODE_READY);
    end
    drain_ring();
    // fill to full with all ops blocked on one external tag
    // one wakeup readies the whole ring at once
    ord_next = next_id;
    repeat (ENTRY_SIZE) begin
      step_cycle();
      if (credits > 0) dispatch_op(MODE_FILL);
    end
    repeat (4) step_cycle();
    check_credit(credits, 0, "credits with ring full");
    drain_ring();
    ordered = 1'b0;
    repeat (RAND_CYC) begin
      step_cycle();
      if (credits > 0 && take_bits(2) != 0) dispatch_op(MODE_RAND);
      if (take_bits(1) != 0) drive_ext(EXT_BASE + take_bits(3));
    end
    drain_ring();
    check_credit(total_ret, total_disp, "credits returned vs ops dispatched");
    $display("errors: done %0d, credit %0d, other %0d (dispatched %0d)",
             n_err_done, n_err_credit, n_err_other, total_disp);
    if (n_err_done + n_err_credit + n_err_other == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(WDOG_TIME);
    $display("watchdog expired after %0d time units, scheduler did not drain", WDOG_TIME);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/sched_age_picker.sv ====
`default_nettype none

module sched_age_picker #(
  parameter int ENTRY_SIZE = 8
) (
  input  wire [ENTRY_SIZE-1:0]         i_req,
  input  wire [$clog2(ENTRY_SIZE)-1:0] i_out_ptr,
  output logic [ENTRY_SIZE-1:0]        o_grant_oh
);

  logic [2*ENTRY_SIZE-1:0] w_req_shr;
  logic [ENTRY_SIZE-1:0]   w_req_rot;
  logic [ENTRY_SIZE-1:0]   w_low_oh;
  logic [2*ENTRY_SIZE-1:0] w_grant_shl;

  // out pointer becomes bit 0
  assign w_req_shr = {i_req, i_req} >> i_out_ptr;
  assign w_req_rot = w_req_shr[ENTRY_SIZE-1:0];

  assign w_low_oh = w_req_rot & (-w_req_rot); // oldest ready

  // rotate back to slot numbering
  assign w_grant_shl = {w_low_oh, w_low_oh} << i_out_ptr;
  assign o_grant_oh  = w_grant_shl[2*ENTRY_SIZE-1:ENTRY_SIZE];

endmodule

`default_nettype wire

// ==== verilog/sched_entry.sv ====
`default_nettype none

module sched_entry (
  input  wire                     i_clk,
  input  wire                     i_arst_n,
  input  wire                     i_put,
  input  wire sched_pkg::disp_t   i_put_data,
  input  wire sched_pkg::wakeup_t i_wakeup_int,
  input  wire sched_pkg::wakeup_t i_wakeup_ext,
  input  wire                     i_picked,
  input  wire                     i_pipe_done,
  input  wire                     i_retire,
  output logic                    o_ready,
  output sched_pkg::issue_t       o_entry,
  output sched_pkg::sched_state_e o_state
);

  import sched_pkg::*;

  sched_state_e r_state;
  disp_t        r_data;
  disp_t        w_nxt;

  // either bus broadcasting this tag
  function automatic logic tag_hit(input logic [TAG_W-1:0] tag);
    return (i_wakeup_int.valid && i_wakeup_int.tag == tag) ||
           (i_wakeup_ext.valid && i_wakeup_ext.tag == tag);
  endfunction

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_state <= ST_INIT;
    end else begin
      case (r_state)
        ST_INIT:   if (i_put) r_state <= ST_WAIT;
        ST_WAIT:   if (i_picked) r_state <= ST_ISSUED;
        ST_ISSUED: if (i_pipe_done) r_state <= ST_DONE;
        ST_DONE:   if (i_retire) r_state <= ST_INIT;
        default:   r_state <= ST_INIT;
      endcase
    end
  end

  // incoming op also sees this cycle's wakeups
  always_comb begin
    w_nxt = i_put ? i_put_data : r_data;
    if (w_nxt.rs1_valid && !w_nxt.rs1_ready && tag_hit(w_nxt.rs1_tag)) begin
      w_nxt.rs1_ready = 1'b1;
    end
    if (w_nxt.rs2_valid && !w_nxt.rs2_ready && tag_hit(w_nxt.rs2_tag)) begin
      w_nxt.rs2_ready = 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    r_data <= w_nxt;
  end

  assign o_ready = (r_state == ST_WAIT) &&
                   (!r_data.rs1_valid || r_data.rs1_ready) &&
                   (!r_data.rs2_valid || r_data.rs2_ready);

  assign o_entry = '{
    valid:  (r_state != ST_INIT),
    cmt_id: r_data.cmt_id,
    op:     r_data.op,
    rd:     r_data.rd
  };

  assign o_state = r_state;

endmodule

`default_nettype wire

// ==== verilog/sched_exec_pipe.sv ====
`default_nettype none

module sched_exec_pipe #(
  parameter int ENTRY_SIZE = 8,
  parameter int EXEC_LAT   = 2
) (
  input  wire                    i_clk,
  input  wire                    i_arst_n,
  input  wire sched_pkg::issue_t i_issue,
  input  wire [ENTRY_SIZE-1:0]   i_iss_index_oh,
  output sched_pkg::wakeup_t     o_wb_wakeup,
  output logic                   o_done_valid,
  output logic [ENTRY_SIZE-1:0]  o_done_index_oh
);

  import sched_pkg::*;

  typedef struct packed {
    logic [TAG_W-1:0]      tag;
    logic [ENTRY_SIZE-1:0] idx_oh;
  } stage_t;

  logic [EXEC_LAT-1:0] r_valid;
  stage_t              r_stage [EXEC_LAT];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_valid <= '0;
    end else begin
      r_valid[0] <= i_issue.valid;
      for (int i = 1; i < EXEC_LAT; i++) begin
        r_valid[i] <= r_valid[i-1];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    r_stage[0] <= '{tag: i_issue.rd, idx_oh: i_iss_index_oh};
    for (int i = 1; i < EXEC_LAT; i++) begin
      r_stage[i] <= r_stage[i-1];
    end
  end

  // last stage is the completion cycle
  assign o_wb_wakeup     = '{valid: r_valid[EXEC_LAT-1], tag: r_stage[EXEC_LAT-1].tag};
  assign o_done_valid    = r_valid[EXEC_LAT-1];
  assign o_done_index_oh = r_stage[EXEC_LAT-1].idx_oh;

endmodule

`default_nettype wire

// ==== verilog/sched_issue_queue.sv ====
`default_nettype none

module sched_issue_queue #(
  parameter int ENTRY_SIZE = 8
) (
  input  wire                     i_clk,
  input  wire                     i_arst_n,
  input  wire                     i_disp_valid,
  input  wire sched_pkg::disp_t   i_disp,
  input  wire sched_pkg::wakeup_t i_wakeup_int,
  input  wire sched_pkg::wakeup_t i_wakeup_ext,
  input  wire                     i_pipe_done,
  input  wire [ENTRY_SIZE-1:0]    i_pipe_done_oh,
  output sched_pkg::issue_t       o_issue,
  output logic [ENTRY_SIZE-1:0]   o_iss_index_oh,
  output sched_pkg::done_rpt_t    o_done_report,
  output logic                    o_credit_ret
);

  import sched_pkg::*;

  localparam int PTR_W = $clog2(ENTRY_SIZE);

  logic [PTR_W-1:0]      w_in_ptr;
  logic [PTR_W-1:0]      w_out_ptr;
  logic [ENTRY_SIZE-1:0] w_ready;
  logic [ENTRY_SIZE-1:0] w_grant_oh;
  logic [ENTRY_SIZE-1:0] w_done_oh;
  issue_t                w_entry [ENTRY_SIZE];
  sched_state_e          w_state [ENTRY_SIZE];
  issue_t                w_done_sel;
  logic                  w_pop;

  logic                  r_done_valid;
  logic [CMT_W-1:0]      r_done_cmt_id;
  logic                  r_done_exc;
  logic                  r_credit_ret;

  function automatic issue_t oh_select(input logic [ENTRY_SIZE-1:0] oh,
                                       input issue_t data [ENTRY_SIZE]);
    issue_t sel;
    sel = '0;
    for (int i = 0; i < ENTRY_SIZE; i++) begin
      sel = sel | (data[i] & {$bits(issue_t){oh[i]}});
    end
    return sel;
  endfunction

  assign w_pop = (w_state[w_out_ptr] == ST_DONE); // in-order retire

  sched_ptr_ring #(.ENTRY_SIZE(ENTRY_SIZE)) u_ptr_ring (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_push    (i_disp_valid),
    .i_pop     (w_pop),
    .o_in_ptr  (w_in_ptr),
    .o_out_ptr (w_out_ptr)
  );

  sched_age_picker #(.ENTRY_SIZE(ENTRY_SIZE)) u_age_picker (
    .i_req      (w_ready),
    .i_out_ptr  (w_out_ptr),
    .o_grant_oh (w_grant_oh)
  );

  for (genvar s_idx = 0; s_idx < ENTRY_SIZE; s_idx++) begin : g_entry
    sched_entry u_entry (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_put        (i_disp_valid && (w_in_ptr == PTR_W'(s_idx))),
      .i_put_data   (i_disp),
      .i_wakeup_int (i_wakeup_int),
      .i_wakeup_ext (i_wakeup_ext),
      .i_picked     (w_grant_oh[s_idx]),
      .i_pipe_done  (w_done_oh[s_idx]),
      .i_retire     (w_pop && (w_out_ptr == PTR_W'(s_idx))),
      .o_ready      (w_ready[s_idx]),
      .o_entry      (w_entry[s_idx]),
      .o_state      (w_state[s_idx])
    );
  end

  assign o_issue        = oh_select(w_grant_oh, w_entry);
  assign o_iss_index_oh = w_grant_oh;

  assign w_done_oh  = i_pipe_done_oh & {ENTRY_SIZE{i_pipe_done}};
  assign w_done_sel = oh_select(w_done_oh, w_entry);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_done_valid <= 1'b0;
      r_credit_ret <= 1'b0;
    end else begin
      r_done_valid <= i_pipe_done;
      r_credit_ret <= w_pop; // one credit per retired slot
    end
  end

  always_ff @(posedge i_clk) begin
    r_done_cmt_id <= w_done_sel.cmt_id;
    r_done_exc    <= (w_done_sel.op == OP_TRAP);
  end

  assign o_done_report = '{valid: r_done_valid, cmt_id: r_done_cmt_id, exc_valid: r_done_exc};
  assign o_credit_ret  = r_credit_ret;

endmodule

`default_nettype wire

// ==== verilog/sched_pkg.sv ====
`default_nettype none

package sched_pkg;

  localparam int TAG_W = 5; // physical tag
  localparam int CMT_W = 6; // commit id

  typedef enum logic [1:0] {
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_TRAP // completes with exception
  } op_e;

  typedef enum logic [1:0] {
    ST_INIT,   // free
    ST_WAIT,   // waiting on sources, or ready
    ST_ISSUED, // in the pipe
    ST_DONE    // completed, not yet retired
  } sched_state_e;

  typedef struct packed {
    logic [CMT_W-1:0] cmt_id;
    op_e              op;
    logic [TAG_W-1:0] rd;
    logic             rs1_valid;
    logic [TAG_W-1:0] rs1_tag;
    logic             rs1_ready;
    logic             rs2_valid;
    logic [TAG_W-1:0] rs2_tag;
    logic             rs2_ready;
  } disp_t;

  typedef struct packed {
    logic             valid;
    logic [CMT_W-1:0] cmt_id;
    op_e              op;
    logic [TAG_W-1:0] rd;
  } issue_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } wakeup_t;

  typedef struct packed {
    logic             valid;
    logic [CMT_W-1:0] cmt_id;
    logic             exc_valid;
  } done_rpt_t;

endpackage

`default_nettype wire

// ==== verilog/sched_ptr_ring.sv ====
`default_nettype none

module sched_ptr_ring #(
  parameter int ENTRY_SIZE = 8
) (
  input  wire                          i_clk,
  input  wire                          i_arst_n,
  input  wire                          i_push,
  input  wire                          i_pop,
  output logic [$clog2(ENTRY_SIZE)-1:0] o_in_ptr,
  output logic [$clog2(ENTRY_SIZE)-1:0] o_out_ptr
);

  localparam int PTR_W = $clog2(ENTRY_SIZE);

  logic [PTR_W-1:0] r_in_ptr;
  logic [PTR_W-1:0] r_out_ptr;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(ENTRY_SIZE - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // push and pop are independent, both may fire in one cycle
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
    end else begin
      if (i_push) r_in_ptr <= next_ptr(r_in_ptr);
      if (i_pop) r_out_ptr <= next_ptr(r_out_ptr);
    end
  end

  assign o_in_ptr  = r_in_ptr;
  assign o_out_ptr = r_out_ptr;

endmodule

`default_nettype wire

// ==== verilog/sched_unit.sv ====
`default_nettype none

module sched_unit #(
  parameter int ENTRY_SIZE = 8,
  parameter int EXEC_LAT   = 2
) (
  input  wire                     i_clk,
  input  wire                     i_arst_n,
  input  wire                     i_disp_valid,
  input  wire sched_pkg::disp_t   i_disp,
  input  wire sched_pkg::wakeup_t i_ext_wakeup,
  output sched_pkg::done_rpt_t    o_done_report,
  output logic                    o_credit_ret
);

  import sched_pkg::*;

  issue_t                w_issue;
  logic [ENTRY_SIZE-1:0] w_iss_index_oh;
  wakeup_t               w_wb_wakeup;
  logic                  w_done_valid;
  logic [ENTRY_SIZE-1:0] w_done_index_oh;

  sched_issue_queue #(.ENTRY_SIZE(ENTRY_SIZE)) u_issue_queue (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_disp_valid   (i_disp_valid),
    .i_disp         (i_disp),
    .i_wakeup_int   (w_wb_wakeup),
    .i_wakeup_ext   (i_ext_wakeup),
    .i_pipe_done    (w_done_valid),
    .i_pipe_done_oh (w_done_index_oh),
    .o_issue        (w_issue),
    .o_iss_index_oh (w_iss_index_oh),
    .o_done_report  (o_done_report),
    .o_credit_ret   (o_credit_ret)
  );

  sched_exec_pipe #(.ENTRY_SIZE(ENTRY_SIZE), .EXEC_LAT(EXEC_LAT)) u_exec_pipe (
    .i_clk           (i_clk),
    .i_arst_n        (i_arst_n),
    .i_issue         (w_issue),
    .i_iss_index_oh  (w_iss_index_oh),
    .o_wb_wakeup     (w_wb_wakeup),
    .o_done_valid    (w_done_valid),
    .o_done_index_oh (w_done_index_oh)
  );

endmodule

`default_nettype wire
